// ==== compile.f ====
source/counterPkg.sv
source/eventCollector.sv
source/counterControlCsrs.sv
source/hpmCounterBank.sv
source/counterCsrTop.sv
testbench/counterCsrTb.sv

// ==== testbench/counterCsrTb.sv ====
/*
  directed testbench for counterCsrTop, built with xlen 32 and all 32 counters
  inputs change on the falling edge, reads are sampled 1 ns after it
  expected counts assume the tests run in this order straight after reset
*/
`timescale 1ns/10ps
`default_nettype none

module counterCsrTb
  import counterPkg::*;
();

  localparam int xlen          = 32;
  localparam int numCounters   = 32;
  localparam int timeoutCycles = 2000;  // tests take about 200 cycles
  localparam int cycleGap      = 20;    // clocks between cycle reads
  localparam int pulseCount    = 3;     // pulses per event class

  logic        clk;
  logic        reset;
  csrReq_t     req;
  hpmEvents_t  events;
  pipeCtrl_t   pipe;
  logic [63:0] mtime;
  csrResp_t    resp;

  integer seed = 86139;
  int errorCount  = 0;
  int testsPassed = 0;
  int testsFailed = 0;
  int cycles      = 0;

  counterCsrTop #(
    .xlen        (xlen),
    .numCounters (numCounters)
  ) counterCsrTop_i (
    .clk, .reset, .req, .events, .pipe, .mtime, .resp
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // watchdog, ends a hung run
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeoutCycles) begin
      $display("timeout: run did not finish within %0d cycles", timeoutCycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // compare and access helpers
  ////////////////////////////////////////////////////////////
  task automatic compareVal(input string sig, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, sig, expected, actual);
      errorCount++;
    end
  endtask

  task automatic compareIllegal(input string sig, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %b got %b", $time, sig, expected, actual);
      errorCount++;
    end
  endtask

  // call in the low phase, no clock edge is consumed
  task automatic readCsr(input logic [11:0] adr, input privMode_t priv, output csrResp_t r);
    req.adr    = adr;
    req.priv   = priv;
    req.write  = 1'b0;
    req.mWrite = 1'b0;
    #1;                // combinational read settles
    r = resp;
  endtask

  // machine level write, returns at the negedge after it landed
  task automatic writeCsr(input logic [11:0] adr, input logic [63:0] val);
    @(negedge clk);
    req.adr      = adr;
    req.priv     = machineMode;
    req.write    = 1'b1;
    req.mWrite   = 1'b1;
    req.writeVal = val;
    @(negedge clk);
    req.write    = 1'b0;
    req.mWrite   = 1'b0;
    req.writeVal = '0;
  endtask

  task automatic checkRead(input string name, input logic [11:0] adr, input privMode_t priv,
                           input logic [63:0] expVal, input logic expIllegal);
    csrResp_t r;
    readCsr(adr, priv, r);
    compareVal({"resp.readVal @ ", name}, expVal, r.readVal);
    compareIllegal({"resp.illegal @ ", name}, expIllegal, r.illegal);
  endtask

  task automatic reportTest(input string name, input int errBefore);
    if (errorCount == errBefore) begin
      testsPassed++;
      $display("test %s: ok", name);
    end else begin
      testsFailed++;
      $display("test %s: %0d mismatches", name, errorCount - errBefore);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task automatic testCycleCounter();
    csrResp_t    r;
    logic [63:0] c0;
    @(negedge clk);
    readCsr(mhpmCounterBase, machineMode, r);
    c0 = r.readVal;
    repeat (cycleGap) @(negedge clk);
    readCsr(mhpmCounterBase, machineMode, r);
    compareVal("resp.readVal @ mcycle delta", 64'(cycleGap), r.readVal - c0);
    writeCsr(mcountInhibitAdr, 64'h3);  // bit 1 must not stick
    checkRead("mcountinhibit", mcountInhibitAdr, machineMode, 64'h1, 1'b0);
    readCsr(mhpmCounterBase, machineMode, r);
    c0 = r.readVal;
    repeat (cycleGap) @(negedge clk);
    checkRead("mcycle inhibited", mhpmCounterBase, machineMode, c0, 1'b0);
    writeCsr(mcountInhibitAdr, 64'h0);
  endtask

  task automatic testWriteCarry();
    logic [31:0] lo;
    logic [31:0] hi;
    lo = $random(seed) & 32'h7fff_ffff;  // no carry on the edges before the wrap
    hi = $random(seed);
    writeCsr(mhpmCounterBase + 2, {32'b0, lo});
    checkRead("minstret", mhpmCounterBase + 2, machineMode, {32'b0, lo}, 1'b0);
    writeCsr(mhpmCounterHBase + 2, {32'b0, hi});
    checkRead("minstreth", mhpmCounterHBase + 2, machineMode, {32'b0, hi}, 1'b0);
    events.retireValid = 1'b1;           // write wins over the increment
    writeCsr(mhpmCounterBase + 2, 64'hffff_ffff);
    @(negedge clk);                      // low half wraps on this edge
    events.retireValid = 1'b0;
    checkRead("minstret wrap", mhpmCounterBase + 2, machineMode, 64'h0, 1'b0);
    checkRead("minstreth carry", mhpmCounterHBase + 2, machineMode,
              {32'b0, hi + 32'd1}, 1'b0);
  endtask

  task automatic testEventRouting();
    logic [63:0] base [32];
    int          expDelta [32];
    logic [63:0] expVal;
    csrResp_t    r;
    for (int i = 2; i < numCounters; i++) begin
      @(negedge clk);
      readCsr(mhpmCounterBase + i, machineMode, r);
      base[i]     = r.readVal;
      expDelta[i] = 0;
    end
    expDelta[2]  = 4 * pulseCount;  // every retiring class
    expDelta[3]  = pulseCount;      // branch
    expDelta[4]  = pulseCount;      // jump with return goes to returns
    expDelta[5]  = 2 * pulseCount;
    expDelta[14] = pulseCount;      // ungated misses and divider
    expDelta[17] = pulseCount;
    expDelta[24] = pulseCount;
    for (int k = 0; k < pulseCount; k++) begin
      @(negedge clk);
      events             = '0;
      events.retireValid = 1'b1;
      events.instrClass  = 4'b0001;
      @(negedge clk);
      events.instrClass = 4'b0010;
      @(negedge clk);
      events.instrClass = 4'b0100;
      @(negedge clk);
      events.instrClass = 4'b0110;
      // branch and predictor miss without retire, gated off
      @(negedge clk);
      events.retireValid = 1'b0;
      events.instrClass  = 4'b0001;
      events.bpWrong     = 1'b1;
      events.dCacheMiss  = 1'b1;
      events.iCacheMiss  = 1'b1;
      events.divBusy     = 1'b1;
    end
    @(negedge clk);
    events = '0;
    for (int i = 2; i < numCounters; i++) begin
      @(negedge clk);
      expVal = (i > 24) ? 64'h0 : base[i] + 64'(expDelta[i]);  // no source above 24
      checkRead($sformatf("mhpmcounter%0d", i), mhpmCounterBase + i, machineMode,
                expVal, 1'b0);
    end
  endtask

  task automatic testStallPipeline();
    logic [63:0] b;
    csrResp_t    r;
    @(negedge clk);
    readCsr(mhpmCounterBase + 11, machineMode, r);
    b = r.readVal;
    events.loadStallD = 1'b1;  // plain pulse
    @(negedge clk);
    events.loadStallD = 1'b0;
    @(negedge clk);
    checkRead("load stall two edges", mhpmCounterBase + 11, machineMode, b, 1'b0);
    @(negedge clk);
    checkRead("load stall three edges", mhpmCounterBase + 11, machineMode, b + 1, 1'b0);
    @(negedge clk);
    events.loadStallD = 1'b1;
    @(negedge clk);
    events.loadStallD = 1'b0;
    pipe.flushM       = 1'b1;  // clears memory stage as the pulse arrives
    @(negedge clk);
    pipe.flushM = 1'b0;
    repeat (2) @(negedge clk);
    checkRead("flushed stall", mhpmCounterBase + 11, machineMode, b + 1, 1'b0);
    events.loadStallD = 1'b1;  // decode holds it while execute stalls
    pipe.stallE       = 1'b1;
    repeat (3) @(negedge clk);
    checkRead("held stall", mhpmCounterBase + 11, machineMode, b + 1, 1'b0);
    pipe.stallE = 1'b0;
    @(negedge clk);
    events.loadStallD = 1'b0;
    @(negedge clk);
    checkRead("released stall early", mhpmCounterBase + 11, machineMode, b + 1, 1'b0);
    @(negedge clk);
    checkRead("released stall", mhpmCounterBase + 11, machineMode, b + 2, 1'b0);
    @(negedge clk);
    checkRead("released stall once", mhpmCounterBase + 11, machineMode, b + 2, 1'b0);
  endtask

  task automatic testPrivilege();
    @(negedge clk);
    checkRead("user cycle", hpmCounterBase, userMode, 64'h0, 1'b1);
    checkRead("user time", timeAdr, userMode, 64'h0, 1'b1);
    checkRead("user hpm3", hpmCounterBase + 3, userMode, 64'h0, 1'b1);
    writeCsr(mcounterEnAdr, 64'h8);
    checkRead("super hpm3", hpmCounterBase + 3, supervisorMode, 64'(pulseCount), 1'b0);
    checkRead("user hpm3 mEn only", hpmCounterBase + 3, userMode, 64'h0, 1'b1);
    writeCsr(sCounterEnAdr, 64'h8);
    checkRead("user hpm3 both", hpmCounterBase + 3, userMode, 64'(pulseCount), 1'b0);
    checkRead("super mcounteren", mcounterEnAdr, supervisorMode, 64'h0, 1'b1);
    checkRead("machine mcounteren", mcounterEnAdr, machineMode, 64'h8, 1'b0);
    checkRead("user scounteren", sCounterEnAdr, userMode, 64'h0, 1'b1);
  endtask

  task automatic testTimeAndIllegal();
    @(negedge clk);
    mtime = {$random(seed), $random(seed)};
    checkRead("time", timeAdr, machineMode, {32'b0, mtime[31:0]}, 1'b0);
    checkRead("timeh", timeHAdr, machineMode, {32'b0, mtime[63:32]}, 1'b0);
    checkRead("mtime csr", mtimeAdr, machineMode, 64'h0, 1'b1);  // also mhpmcounter1
    checkRead("mtimeh csr", mtimeHAdr, machineMode, 64'h0, 1'b1);
    checkRead("beyond counters", mhpmCounterBase + numCounters, machineMode, 64'h0, 1'b1);
    checkRead("beyond user", hpmCounterBase + numCounters, machineMode, 64'h0, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int errBefore;
    reset    = 1'b1;
    req      = '0;
    req.priv = machineMode;
    events   = '0;
    pipe     = '0;
    mtime    = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    errBefore = errorCount;
    testCycleCounter();
    reportTest("cycle counter", errBefore);
    errBefore = errorCount;
    testWriteCarry();
    reportTest("write and carry", errBefore);
    errBefore = errorCount;
    testEventRouting();
    reportTest("event routing", errBefore);
    errBefore = errorCount;
    testStallPipeline();
    reportTest("stall pipeline", errBefore);
    errBefore = errorCount;
    testPrivilege();
    reportTest("privilege", errBefore);
    errBefore = errorCount;
    testTimeAndIllegal();
    reportTest("time and illegal", errBefore);

    $display("tests passed %0d, failed %0d", testsPassed, testsFailed);
    if (testsFailed == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/counterCsrTop.sv ====
/*
  top of the counter CSR block
  reads are combinational, zero cycle latency from req to resp
  writes land at the next rising edge
*/
`timescale 1ns/10ps
`default_nettype none

module counterCsrTop
  import counterPkg::*;
#(
  parameter int xlen        = 32,  // 32 or 64
  parameter int numCounters = 32   // 3 to 32
) (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire csrReq_t     req,
  input  wire hpmEvents_t  events,
  input  wire pipeCtrl_t   pipe,
  input  wire logic [63:0] mtime,    // external machine timer
  output csrResp_t         resp
);

  logic [numCounters-1:0] counterEvent;
  logic [31:0]            inhibit, mEn, sEn;
  csrResp_t               ctrlResp, bankResp;
  logic                   ctrlHit;

  eventCollector #(
    .numCounters (numCounters)
  ) eventCollector_i (
    .clk, .reset, .events, .pipe,
    .counterEvent
  );

  counterControlCsrs counterControlCsrs_i (
    .clk, .reset, .req,
    .inhibit, .mEn, .sEn,
    .ctrlResp, .ctrlHit
  );

  hpmCounterBank #(
    .xlen        (xlen),
    .numCounters (numCounters)
  ) hpmCounterBank_i (
    .clk, .reset, .req, .counterEvent,
    .inhibit, .mEn, .sEn, .mtime,
    .bankResp
  );

  // control registers take priority on their own addresses
  assign resp = ctrlHit ? ctrlResp : bankResp;

endmodule

`default_nettype wire

// ==== source/hpmCounterBank.sv ====
/*
  counter storage, increment and CSR read mux
  xlen 32 keeps each counter as two halves written separately, carry ripples up
  counters at or above numCounters read as illegal
  mtime/mtimeh CSR numbers always fault, time reads come from the outside timer
*/
`timescale 1ns/10ps
`default_nettype none

module hpmCounterBank
  import counterPkg::*;
#(
  parameter int xlen        = 32,
  parameter int numCounters = 32
) (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire csrReq_t                req,
  input  wire logic [numCounters-1:0] counterEvent,
  input  wire logic [31:0]            inhibit,
  input  wire logic [31:0]            mEn,
  input  wire logic [31:0]            sEn,
  input  wire logic [63:0]            mtime,
  output csrResp_t                    bankResp
);

  logic [63:0]            cnt     [numCounters];  // full 64 bit value either way
  logic [63:0]            cntPlus [numCounters];  // value plus event
  logic [63:0]            nextCnt [numCounters];
  logic [xlen-1:0]        nextLo  [numCounters];  // low half, or whole on rv64
  logic [numCounters-1:0] wrLo;                   // low half write strobes
  logic [numCounters-1:0] incr;                   // event and not inhibited

  logic [4:0]             cntNum;                 // counter selected by address
  logic                   readOk;                 // privilege check passed
  logic [xlen-1:0]        rdVal;

  assign incr = counterEvent & ~inhibit[numCounters-1:0];

  //////////////////////////////////////////////////////////////
  // counter registers
  //////////////////////////////////////////////////////////////
  for (genvar i = 0; i < numCounters; i++) begin : gCnt
    // slot 1 is mtime, never a CSR write target
    assign wrLo[i]    = req.mWrite && (req.adr == mhpmCounterBase + i) && (i != 1);
    assign cntPlus[i] = cnt[i] + 64'(incr[i]);
    assign nextLo[i]  = wrLo[i] ? req.writeVal[xlen-1:0] : cntPlus[i][xlen-1:0];

    if (xlen == 32) begin : gHalves
      logic        wrHi;
      logic [31:0] nextHi;

      assign wrHi       = req.mWrite && (req.adr == mhpmCounterHBase + i) && (i != 1);
      // write wins over the carry from the low half
      assign nextHi     = wrHi ? req.writeVal[31:0] : cntPlus[i][63:32];
      assign nextCnt[i] = {nextHi, nextLo[i]};
    end else begin : gWhole
      assign nextCnt[i] = nextLo[i];  // rv64, one register
    end

    always_ff @(posedge clk) begin
      if (reset)
        cnt[i] <= '0;
      else
        cnt[i] <= nextCnt[i];
    end
  end

  //////////////////////////////////////////////////////////////
  // read mux and privilege check
  //////////////////////////////////////////////////////////////
  assign cntNum = req.adr[4:0];

  // machine always, supervisor via mcounteren, user needs both enables
  assign readOk = (req.priv == machineMode) ||
                  (mEn[cntNum] && ((req.priv == supervisorMode) || sEn[cntNum]));

  always_comb begin
    rdVal            = '0;
    bankResp.illegal = 1'b1;           // fault unless a case below matches
    if (readOk) begin
      bankResp.illegal = 1'b0;
      if (req.adr == timeAdr) begin
        rdVal = mtime[xlen-1:0];       // shadow of memory mapped timer
      end else if (xlen == 32 && req.adr == timeHAdr) begin
        rdVal = mtime[63:32];
      end else if (req.adr >= mhpmCounterBase &&
                   req.adr < mhpmCounterBase + numCounters &&
                   req.adr != mtimeAdr) begin
        rdVal = cnt[cntNum][xlen-1:0];
      end else if (req.adr >= hpmCounterBase &&
                   req.adr < hpmCounterBase + numCounters) begin
        rdVal = cnt[cntNum][xlen-1:0]; // user shadow
      end else if (xlen == 32 &&
                   req.adr >= mhpmCounterHBase &&
                   req.adr < mhpmCounterHBase + numCounters &&
                   req.adr != mtimeHAdr) begin
        rdVal = cnt[cntNum][63:32];
      end else if (xlen == 32 &&
                   req.adr >= hpmCounterHBase &&
                   req.adr < hpmCounterHBase + numCounters) begin
        rdVal = cnt[cntNum][63:32];
      end else begin
        bankResp.illegal = 1'b1;       // no such counter
      end
    end
    bankResp.readVal = 64'(rdVal);     // zero above xlen
  end

endmodule

`default_nettype wire

// ==== source/counterControlCsrs.sv ====
/*
  mcountinhibit, mcounteren and scounteren
  all three are written only through mWrite, i.e. at machine level
  inhibit bit 1 is hardwired low since time cannot be stopped
*/
`timescale 1ns/10ps
`default_nettype none

module counterControlCsrs
  import counterPkg::*;
(
  input  wire logic    clk,
  input  wire logic    reset,
  input  wire csrReq_t req,
  output logic [31:0]  inhibit,
  output logic [31:0]  mEn,
  output logic [31:0]  sEn,
  output csrResp_t     ctrlResp,
  output logic         ctrlHit
);

  logic hitInhibit;  // mcountinhibit addressed
  logic hitMEn;      // mcounteren addressed
  logic hitSEn;      // scounteren addressed
  logic isMachine;
  logic isSuper;

  //////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////
  assign hitInhibit = (req.adr == mcountInhibitAdr);
  assign hitMEn     = (req.adr == mcounterEnAdr);
  assign hitSEn     = (req.adr == sCounterEnAdr);
  assign ctrlHit    = hitInhibit | hitMEn | hitSEn;

  assign isMachine  = (req.priv == machineMode);
  assign isSuper    = (req.priv == supervisorMode);

  //////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      inhibit <= '0;
      mEn     <= '0;
      sEn     <= '0;
    end else if (req.mWrite) begin
      if (hitInhibit)
        inhibit <= req.writeVal[31:0] & ~32'h2;  // keep time running
      if (hitMEn)
        mEn <= req.writeVal[31:0];
      if (hitSEn)
        sEn <= req.writeVal[31:0];
    end
  end

  //////////////////////////////////////////////////////////////
  // read path, same cycle
  //////////////////////////////////////////////////////////////
  always_comb begin
    ctrlResp = '0;
    if (hitInhibit) begin
      if (isMachine)
        ctrlResp.readVal = {32'b0, inhibit};
      else
        ctrlResp.illegal = 1'b1;       // machine only
    end else if (hitMEn) begin
      if (isMachine)
        ctrlResp.readVal = {32'b0, mEn};
      else
        ctrlResp.illegal = 1'b1;       // machine only
    end else if (hitSEn) begin
      // supervisor or machine may see scounteren
      if (isMachine || isSuper)
        ctrlResp.readVal = {32'b0, sEn};
      else
        ctrlResp.illegal = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/eventCollector.sv ====
/*
  builds the per-counter increment strobes
  event sources are fixed by counter number, no mhpmevent selectors
  load and store stalls are delayed two stages to line up with memory stage
*/
`timescale 1ns/10ps
`default_nettype none

module eventCollector
  import counterPkg::*;
#(
  parameter int numCounters = 32
) (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire hpmEvents_t             events,
  input  wire pipeCtrl_t              pipe,
  output logic [numCounters-1:0]      counterEvent
);

  logic        loadStallE, storeStallE;  // execute stage copies
  logic        loadStallM, storeStallM;  // memory stage copies
  logic        rv;                       // retire qualifier
  logic [31:0] allEvents;                // full 32 counter view

  //////////////////////////////////////////////////////////////
  // stall pipeline
  //////////////////////////////////////////////////////////////
  // decode to execute, held while execute stalls
  always_ff @(posedge clk) begin
    if (reset) begin
      loadStallE  <= 1'b0;
      storeStallE <= 1'b0;
    end else if (!pipe.stallE) begin
      loadStallE  <= events.loadStallD;
      storeStallE <= events.storeStallD;
    end
  end

  // execute to memory, flush drops the pending stall
  always_ff @(posedge clk) begin
    if (reset || pipe.flushM) begin
      loadStallM  <= 1'b0;
      storeStallM <= 1'b0;
    end else if (!pipe.stallM) begin
      loadStallM  <= loadStallE;
      storeStallM <= storeStallE;
    end
  end

  //////////////////////////////////////////////////////////////
  // event map
  //////////////////////////////////////////////////////////////
  assign rv = events.retireValid;

  always_comb begin
    allEvents     = '0;                        // counters 25 and up have no source
    allEvents[0]  = 1'b1;                      // cycle
    allEvents[1]  = 1'b0;                      // time slot, never counts here
    allEvents[2]  = rv;                        // instret
    allEvents[3]  = rv & events.instrClass[0]; // branches
    // jumps, minus returns
    allEvents[4]  = rv & events.instrClass[1] & ~events.instrClass[2];
    allEvents[5]  = rv & events.instrClass[2]; // returns
    allEvents[6]  = rv & events.bpWrong;
    allEvents[7]  = rv & events.bpDirWrong;
    allEvents[8]  = rv & events.btaWrong;
    allEvents[9]  = rv & events.rasWrong;
    allEvents[10] = rv & events.iclassWrong;
    allEvents[11] = loadStallM;                // not gated, flush already handled
    allEvents[12] = storeStallM;
    allEvents[13] = rv & events.dCacheAccess;
    allEvents[14] = events.dCacheMiss;
    allEvents[15] = events.dCacheStall;
    allEvents[16] = rv & events.iCacheAccess;
    allEvents[17] = events.iCacheMiss;
    allEvents[18] = events.iCacheStall;
    allEvents[19] = rv & events.csrWrite;
    allEvents[20] = rv & events.fenceI;
    allEvents[21] = rv & events.sfenceVma;
    allEvents[22] = events.interrupt;          // retireValid low on traps
    allEvents[23] = events.exception;
    allEvents[24] = events.divBusy;
  end

  assign counterEvent = allEvents[numCounters-1:0];

endmodule

`default_nettype wire

// ==== source/counterPkg.sv ====
/*
  shared types and CSR addresses for the counter block
  only the low xlen bits of writeVal and readVal carry data
  privilege encoding follows the RISC-V spec, level 2 is reserved
*/
`default_nettype none

package counterPkg;

  //////////////////////////////////////////////////////////////
  // privilege levels
  //////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    userMode       = 2'd0,
    supervisorMode = 2'd1,
    machineMode    = 2'd3
  } privMode_t;

  //////////////////////////////////////////////////////////////
  // CSR addresses
  //////////////////////////////////////////////////////////////
  localparam logic [11:0] mhpmCounterBase  = 12'hB00;  // mcycle, minstret, mhpmcounter3..
  localparam logic [11:0] mhpmCounterHBase = 12'hB80;  // high halves, rv32 only
  localparam logic [11:0] hpmCounterBase   = 12'hC00;  // user read-only shadows
  localparam logic [11:0] hpmCounterHBase  = 12'hC80;
  localparam logic [11:0] timeAdr          = 12'hC01;
  localparam logic [11:0] timeHAdr         = 12'hC81;
  // mtime lives in memory space, so these CSR numbers must fault
  localparam logic [11:0] mtimeAdr         = 12'hB01;
  localparam logic [11:0] mtimeHAdr        = 12'hB81;
  localparam logic [11:0] mcountInhibitAdr = 12'h320;
  localparam logic [11:0] mcounterEnAdr    = 12'h306;
  localparam logic [11:0] sCounterEnAdr    = 12'h106;

  //////////////////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [11:0] adr;       // CSR number in memory stage
    privMode_t   priv;      // current privilege level
    logic        write;     // some CSR write is retiring
    logic        mWrite;    // write allowed at machine level
    logic [63:0] writeVal;  // low xlen bits used
  } csrReq_t;

  typedef struct packed {
    logic       retireValid;  // instruction retires, not flushed
    logic [3:0] instrClass;   // 0 branch, 1 jump, 2 return
    logic       bpWrong;      // any predictor miss
    logic       bpDirWrong;   // wrong direction
    logic       btaWrong;     // wrong target
    logic       rasWrong;     // return stack wrong
    logic       iclassWrong;  // class predictor wrong
    logic       loadStallD;   // load-use stall, decode stage
    logic       storeStallD;  // store stall, decode stage
    logic       dCacheAccess;
    logic       dCacheMiss;   // one cycle at start of miss
    logic       dCacheStall;  // miss cycles
    logic       iCacheAccess;
    logic       iCacheMiss;
    logic       iCacheStall;
    logic       csrWrite;
    logic       fenceI;
    logic       sfenceVma;
    logic       interrupt;
    logic       exception;
    logic       divBusy;      // divider busy cycles
  } hpmEvents_t;

  typedef struct packed {
    logic stallE;
    logic stallM;
    logic flushM;
  } pipeCtrl_t;

  typedef struct packed {
    logic [63:0] readVal;  // upper bits zero above xlen
    logic        illegal;  // access faults
  } csrResp_t;

endpackage

`default_nettype wire
